// File: verification/proc_input.txt
# T name | P instruction word (hex) | W reg data (hex) expected writeback
# E expected err flag, closes the test
T rformat
P C135
P C20C
P D94C
P D951
P DA35
P D95A
P D95F
P C181
P 9135
P C204
P D14C
P D151
P D156
P D15B
P 0000
W 1 0035
W 2 000C
W 3 0041
W 4 0029
W 5 FFD7
W 6 0039
W 7 0031
W 1 FF81
W 1 8135
W 2 0004
W 3 1358
W 4 1350
W 5 5813
W 6 0813
E 0
T immediate
P C110
P 415D
P 4965
P 519F
P C6FF
P 5EB3
P A9E3
P B145
P A261
P BE8F
P 91A5
P 0000
W 1 0010
W 2 000D
W 3 000B
W 4 000F
W 6 FFFF
W 5 FFEC
W 7 0080
W 2 8000
W 3 0001
W 4 0001
W 1 10A5
E 0
T memory
P C120
P C27B
P 92CD
P 8144
P 8964
P 995E
P 8980
P 0000
W 1 0020
W 2 007B
W 2 7BCD
W 3 7BCD
W 1 001E
W 4 7BCD
E 0
T set_btr
P C1FE
P C203
P E14C
P E130
P E954
P F238
P F138
P F95C
P FA3C
P CA0C
P C910
P 0000
W 1 FFFE
W 2 0003
W 3 0000
W 4 0001
W 5 0001
W 6 0000
W 6 0001
W 7 0001
W 7 0000
W 3 C000
W 4 7FFF
E 0
T branch_jump
P C000
P C1FF
P C205
P 6002
P C311
P 6202
P C322
P 6A02
P C333
P 7102
P C344
P 7202
P C455
P 7902
P C466
P 7802
P C477
P 2002
P C511
P 3002
P C522
P C232
P 2A02
P C533
P C544
P C555
P 3A08
P C566
P C577
P C57E
P 0000
W 0 0000
W 1 FFFF
W 2 0005
W 3 0022
W 4 0055
W 4 0066
W 7 0028
W 2 0032
W 7 0036
W 5 007E
E 0
T nop_like
P C101
P 0800
P 1000
P 1800
P 4121
P 0000
W 1 0001
W 1 0002
E 0

// File: sim.f
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/control.sv
hw/fetch.sv
hw/execute.sv
hw/proc.sv
verification/tb_clock.sv
verification/proc_checker.sv
verification/tb_proc.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_proc -f sim.f -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log
if grep -q "^TEST PASS$" sim.log; then
   exit 0
fi
echo "Simulation reported failure"
exit 1

// File: verification/tb_proc.sv
module tb_proc
   import isa_pkg::*;
   import ctrl_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int WAIT_LIMIT = 200;      // Cycles allowed per program

   logic       clk;
   logic       rst_n;
   logic       imem_we;
   imem_addr_t imem_addr;
   word_t      imem_data;
   logic       start;
   wb_t        wb;
   logic       halted;
   logic       err;
   int         mismatches;
   int         protocol_errs;
   int         tests_done;
   int         tests_run = 0;
   int         timeouts = 0;
   int         setup_errs = 0;
   int         sequence_errs = 0;

   tb_clock clock_gen (.clk(clk));

   proc proc_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .imem_we   (imem_we),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .start     (start),
      .wb        (wb),
      .halted    (halted),
      .err       (err)
   );

   proc_checker checker_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .wb            (wb),
      .halted        (halted),
      .err           (err),
      .mismatches    (mismatches),
      .protocol_errs (protocol_errs),
      .tests_done    (tests_done)
   );

   task automatic write_word(input int addr, input word_t data);
      @(negedge clk);
      imem_we   = 1'b1;
      imem_addr = imem_addr_t'(addr);
      imem_data = data;
   endtask

   task automatic run_program(input string name, output logic ok);
      int cycles;
      @(negedge clk);
      imem_we = 1'b0;
      start   = 1'b1;
      @(negedge clk);
      start = 1'b0;
      ok    = 1'b0;
      for (cycles = 0; cycles < WAIT_LIMIT && !ok; cycles++) begin
         @(negedge clk);
         ok = halted;
      end
      if (!ok) begin
         $display("Test %s did not halt within %0d cycles", name, WAIT_LIMIT);
         timeouts++;
      end
   endtask

   task automatic report_and_finish();
      if (tests_done != tests_run) begin
         $display("Checker closed %0d tests but %0d programs halted", tests_done, tests_run);
         sequence_errs++;
      end
      $display("errors: mismatches=%0d protocol=%0d timeouts=%0d setup=%0d sequence=%0d",
               mismatches, protocol_errs, timeouts, setup_errs, sequence_errs);
      if (mismatches + protocol_errs + timeouts + setup_errs + sequence_errs == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   endtask

   initial begin
      int    fd;
      int    code;
      int    addr;
      string line;
      string name;
      word_t word;
      logic  ok;
      rst_n     = 1'b0;
      imem_we   = 1'b0;
      imem_addr = '0;
      imem_data = '0;
      start     = 1'b0;
      ok        = 1'b1;
      addr      = 0;
      name      = "";
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      fd = $fopen("verification/proc_input.txt", "r");
      if (fd == 0) begin
         $display("Cannot open verification/proc_input.txt");
         setup_errs++;
      end else begin
         while (ok && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() == 0) continue;
            case (line.getc(0))
               "T": begin
                  code = $sscanf(line, "T %s", name);
                  addr = 0;
               end
               "P": begin
                  code = $sscanf(line, "P %h", word);
                  write_word(addr, word);
                  addr++;
               end
               "E": begin
                  run_program(name, ok);
                  if (ok) tests_run++;
                  repeat (2) @(negedge clk); // Checker sees the halt edge
               end
               default: ;
            endcase
         end
         $fclose(fd);
      end
      report_and_finish();
   end

endmodule

// File: verification/proc_checker.sv
module proc_checker
   import isa_pkg::*;
   import ctrl_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  wb_t  wb,
   input  logic halted,
   input  logic err,
   output int   mismatches,
   output int   protocol_errs,
   output int   tests_done
);

   timeunit 1ns;
   timeprecision 1ps;

   string    test_names [$];
   logic     exp_err [$];
   int       rec_test [$];       // Test number of each expected record
   reg_idx_t rec_idx [$];
   word_t    rec_data [$];
   int       cur = 0;            // Test that is running now
   int       ptr = 0;            // Next expected record
   int       mismatch_cnt = 0;
   int       proto_cnt = 0;
   int       load_errs = 0;
   logic     halted_q = 1'b0;

   assign mismatches    = mismatch_cnt;
   assign protocol_errs = proto_cnt + load_errs;
   assign tests_done    = cur;

   function automatic string test_name(input int t);
      if (t < test_names.size()) return test_names[t];
      return "(none)";
   endfunction

   initial begin : load_expected
      int    fd;
      int    code;
      int    idx;
      int    e;
      string line;
      string name;
      word_t data;
      fd = $fopen("verification/proc_input.txt", "r");
      if (fd == 0) begin
         $display("Checker cannot open verification/proc_input.txt");
         load_errs = 1;
      end else begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() == 0) continue;
            case (line.getc(0))
               "T": begin
                  code = $sscanf(line, "T %s", name);
                  test_names.push_back(name);
               end
               "W": begin
                  code = $sscanf(line, "W %d %h", idx, data);
                  rec_test.push_back(test_names.size() - 1);
                  rec_idx.push_back(reg_idx_t'(idx));
                  rec_data.push_back(data);
               end
               "E": begin
                  code = $sscanf(line, "E %d", e);
                  exp_err.push_back(e != 0);
               end
               default: ;                // Comments and program words
            endcase
         end
         $fclose(fd);
      end
   end

   always @(posedge clk) begin
      if (rst_n) begin
         if (wb.valid) begin
            if (ptr < rec_test.size() && rec_test[ptr] == cur) begin
               if (wb.idx !== rec_idx[ptr] || wb.data !== rec_data[ptr]) begin
                  $display("FAIL %s: expected r%0d=%04h, actual r%0d=%04h", test_name(cur),
                           rec_idx[ptr], rec_data[ptr], wb.idx, wb.data);
                  mismatch_cnt++;
               end
               ptr++;
            end else begin
               $display("Extra writeback in test %s: r%0d=%04h", test_name(cur),
                        wb.idx, wb.data);
               proto_cnt++;
            end
         end
         if (halted && !halted_q) begin  // End of one program
            if (cur >= exp_err.size()) begin
               $display("Core halted while no test was pending");
               proto_cnt++;
            end else if (err !== exp_err[cur]) begin
               $display("FAIL %s: expected err=%0d, actual err=%0d", test_name(cur),
                        exp_err[cur], err);
               mismatch_cnt++;
            end
            while (ptr < rec_test.size() && rec_test[ptr] == cur) begin
               $display("Missing writeback in test %s: r%0d=%04h never written",
                        test_name(cur), rec_idx[ptr], rec_data[ptr]);
               proto_cnt++;
               ptr++;
            end
            cur++;
         end
      end
      halted_q = halted;
   end

endmodule

// File: verification/tb_clock.sv
module tb_clock (
   output logic clk
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam time HALF_PERIOD = 10ns;   // 20 ns period

   initial clk = 1'b0;

   always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: hw/proc.sv
module proc
   import isa_pkg::*;
   import ctrl_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       imem_we,
   input  imem_addr_t imem_addr,
   input  word_t      imem_data,
   input  logic       start,
   output wb_t        wb,
   output logic       halted,
   output logic       err
);

   word_t instr;
   word_t pc;
   word_t next_pc;
   ctrl_t ctrl;
   logic  running;

   fetch fetch_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .imem_we   (imem_we),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .pc_en     (ctrl.pc_en),
      .err_in    (ctrl.err),
      .next_pc   (next_pc),
      .instr     (instr),
      .pc        (pc),
      .running   (running),
      .halted    (halted),
      .err       (err)
   );

   control control_i (
      .instr (instr),
      .ctrl  (ctrl)
   );

   execute execute_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .running (running),
      .instr   (instr),
      .pc      (pc),
      .ctrl    (ctrl),
      .next_pc (next_pc),
      .wb      (wb)
   );

endmodule

// File: hw/execute.sv
module execute
   import isa_pkg::*;
   import ctrl_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  running,
   input  word_t instr,
   input  word_t pc,
   input  ctrl_t ctrl,
   output word_t next_pc,
   output wb_t   wb
);

   word_t       rf [8];
   word_t       dmem [DMEM_WORDS];
   word_t       rs, rt, imm_ext, opb;
   word_t       alu_a, alu_b, sum, rev, alu_res;
   word_t       mem_rdata, set_val, link, br_target, jr_target;
   word_t       lbi_val, slbi_val, wr_data;
   reg_idx_t    wr_idx;
   dmem_addr_t  dmem_addr;
   logic [3:0]  amt;
   logic [16:0] diff;
   logic        eq, ovf, lt, set_bit, br_take;

   assign rs = rf[instr[10:8]];
   assign rt = rf[instr[7:5]];

   always_comb begin
      case (ctrl.sext_op)
         ZEXT5:   imm_ext = {11'b0, instr[4:0]};
         SEXT5:   imm_ext = {{11{instr[4]}}, instr[4:0]};
         SEXT8:   imm_ext = {{8{instr[7]}}, instr[7:0]};
         default: imm_ext = {{5{instr[10]}}, instr[10:0]};
      endcase
   end

   assign opb   = ctrl.oprnd_sel ? imm_ext : rt;
   assign alu_a = ctrl.alu_inv_a ? ~rs : rs;
   assign alu_b = ctrl.alu_inv_b ? ~opb : opb;
   assign sum   = alu_a + alu_b + word_t'(ctrl.alu_cin);
   assign amt   = alu_b[3:0];             // Shift amount

   always_comb begin
      for (int i = 0; i < 16; i++) rev[i] = rs[15-i];
   end

   always_comb begin
      case (ctrl.alu_op)
         ROL:     alu_res = (alu_a << amt) | (alu_a >> (5'd16 - {1'b0, amt}));
         SLL:     alu_res = alu_a << amt;
         ROR:     alu_res = (alu_a >> amt) | (alu_a << (5'd16 - {1'b0, amt}));
         SRL:     alu_res = alu_a >> amt;
         ADD:     alu_res = sum;
         AND:     alu_res = alu_a & alu_b;
         BTR:     alu_res = rev;
         default: alu_res = alu_a ^ alu_b;
      endcase
   end

   // Compare through Rs - Rt
   assign diff = {1'b0, rs} + {1'b0, ~rt} + 17'd1;
   assign eq   = (diff[15:0] == '0);
   assign ovf  = (rs[15] ^ rt[15]) & (diff[15] ^ rs[15]);
   assign lt   = ctrl.alu_sign ? (diff[15] ^ ovf) : ~diff[16];

   always_comb begin
      case (ctrl.set_sel)
         CO:      set_bit = diff[16];     // No borrow
         EQ:      set_bit = eq;
         LT:      set_bit = lt;
         default: set_bit = lt | eq;
      endcase
   end

   assign set_val = {15'b0, set_bit};

   always_comb begin
      case (ctrl.br_cnd)
         EQZ:     br_take = (rs == '0);
         NEZ:     br_take = (rs != '0);
         LTZ:     br_take = rs[15];
         default: br_take = ~rs[15];
      endcase
   end

   assign link      = pc + 16'd2;
   assign br_target = link + imm_ext;
   assign jr_target = rs + imm_ext;

   always_comb begin
      if (ctrl.jmp) next_pc = ctrl.jmp_reg ? jr_target : br_target;
      else if (ctrl.br && br_take) next_pc = br_target;
      else next_pc = link;
   end

   assign dmem_addr = alu_res[8:1];
   assign mem_rdata = ctrl.mem_en ? dmem[dmem_addr] : '0;

   always_ff @(posedge clk) begin
      if (running && ctrl.mem_en && ctrl.mem_wr_en) dmem[dmem_addr] <= rt;
   end

   assign lbi_val  = {{8{instr[7]}}, instr[7:0]};
   assign slbi_val = {rs[7:0], instr[7:0]};

   always_comb begin
      case (ctrl.wr_reg_sel)
         RD_4_2:  wr_idx = instr[4:2];
         RT_7_5:  wr_idx = instr[7:5];
         RS_10_8: wr_idx = instr[10:8];
         default: wr_idx = LINK_REG;
      endcase
   end

   always_comb begin
      case (ctrl.wr_sel)
         MEM:     wr_data = mem_rdata;
         LINK:    wr_data = link;
         SET:     wr_data = set_val;
         IMM:     wr_data = lbi_val;
         SLBI:    wr_data = slbi_val;
         default: wr_data = alu_res;
      endcase
   end

   always_comb begin
      wb.valid = running & ctrl.wr_en;
      wb.idx   = wr_idx;
      wb.data  = wr_data;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) rf <= '{default: '0};
      else if (wb.valid) rf[wb.idx] <= wb.data;
   end

endmodule

// File: hw/fetch.sv
module fetch
   import isa_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       start,
   input  logic       imem_we,
   input  imem_addr_t imem_addr,
   input  word_t      imem_data,
   input  logic       pc_en,
   input  logic       err_in,
   input  word_t      next_pc,
   output word_t      instr,
   output word_t      pc,
   output logic       running,
   output logic       halted,
   output logic       err
);

   typedef enum logic {IDLE, RUN} state_t;

   state_t state;
   word_t  imem [IMEM_WORDS];

   always_ff @(posedge clk) begin
      if (imem_we) imem[imem_addr] <= imem_data;
   end

   assign instr   = imem[pc[8:1]];        // Word aligned
   assign running = (state == RUN);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= IDLE;
         pc     <= '0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (start) begin
         state  <= RUN;
         pc     <= '0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (state == RUN) begin
         if (!pc_en || err_in) begin       // HALT or illegal opcode
            state  <= IDLE;
            halted <= 1'b1;
            err    <= err_in;
         end else begin
            pc <= next_pc;
         end
      end
   end

endmodule

// File: hw/control.sv
module control
   import isa_pkg::*;
   import ctrl_pkg::*;
(
   input  word_t instr,
   output ctrl_t ctrl
);

   opcode_t opcode;

   assign opcode = instr[15:11];

   always_comb begin
      ctrl           = '0;
      ctrl.alu_sign  = 1'b1;
      ctrl.pc_en     = 1'b1;

      case (opcode)
         OP_HALT: ctrl.pc_en = 1'b0;
         OP_NOP, OP_SIIC, OP_RTI: begin
            ctrl.pc_en = 1'b1;                // Only the PC moves
         end
         OP_ADDI, OP_SUBI: begin
            ctrl.wr_en      = 1'b1;
            ctrl.wr_reg_sel = RT_7_5;
            ctrl.oprnd_sel  = 1'b1;
            ctrl.sext_op    = SEXT5;
            ctrl.alu_op     = ADD;
            ctrl.alu_inv_b  = opcode[0];      // SUBI is Rs + ~imm + 1
            ctrl.alu_cin    = opcode[0];
         end
         OP_XORI, OP_ANDNI: begin
            ctrl.wr_en      = 1'b1;
            ctrl.wr_reg_sel = RT_7_5;
            ctrl.oprnd_sel  = 1'b1;
            ctrl.alu_op     = opcode[0] ? AND : XOR;
            ctrl.alu_inv_b  = opcode[0];
         end
         OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
            ctrl.wr_en      = 1'b1;
            ctrl.wr_reg_sel = RT_7_5;
            ctrl.oprnd_sel  = 1'b1;
            ctrl.alu_op     = alu_op_t'({1'b0, opcode[1:0]});
         end
         OP_ST, OP_LD, OP_STU: begin
            ctrl.mem_en     = 1'b1;
            ctrl.mem_wr_en  = (opcode != OP_LD);
            ctrl.wr_en      = (opcode != OP_ST);
            ctrl.wr_sel     = (opcode == OP_LD) ? MEM : ALU;  // STU writes the address
            ctrl.wr_reg_sel = (opcode == OP_STU) ? RS_10_8 : RT_7_5;
            ctrl.oprnd_sel  = 1'b1;
            ctrl.sext_op    = SEXT5;
            ctrl.alu_op     = ADD;
         end
         OP_BTR: begin
            ctrl.wr_en  = 1'b1;
            ctrl.alu_op = BTR;
         end
         OP_SHIFT: begin
            ctrl.wr_en  = 1'b1;
            ctrl.alu_op = alu_op_t'({1'b0, instr[1:0]});
         end
         OP_ARITH: begin
            ctrl.wr_en = 1'b1;
            case (instr[1:0])
               2'b00: ctrl.alu_op = ADD;
               2'b01: begin
                  ctrl.alu_op    = ADD;       // Rs - Rt
                  ctrl.alu_inv_b = 1'b1;
                  ctrl.alu_cin   = 1'b1;
               end
               2'b10: ctrl.alu_op = XOR;
               default: begin
                  ctrl.alu_op    = AND;       // ANDN
                  ctrl.alu_inv_b = 1'b1;
               end
            endcase
         end
         OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
            ctrl.wr_en    = 1'b1;
            ctrl.wr_sel   = SET;
            ctrl.set_sel  = set_sel_t'(opcode[1:0] + 2'd1);  // 11100 -> EQ ... 11111 -> CO
            ctrl.alu_sign = (opcode != OP_SCO);
         end
         OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
            ctrl.br      = 1'b1;
            ctrl.br_cnd  = br_cnd_t'(opcode[1:0]);
            ctrl.sext_op = SEXT8;
         end
         OP_LBI, OP_SLBI: begin
            ctrl.wr_en      = 1'b1;
            ctrl.wr_sel     = (opcode == OP_LBI) ? IMM : SLBI;
            ctrl.wr_reg_sel = RS_10_8;
         end
         OP_J, OP_JR, OP_JAL, OP_JALR: begin
            ctrl.jmp        = 1'b1;
            ctrl.jmp_reg    = opcode[0];      // JR and JALR
            ctrl.sext_op    = opcode[0] ? SEXT8 : SEXT11;
            ctrl.wr_en      = opcode[1];      // JAL and JALR link
            ctrl.wr_sel     = LINK;
            ctrl.wr_reg_sel = R7;
         end
         default: ctrl.err = 1'b1;
      endcase
   end

endmodule

// File: hw/ctrl_pkg.sv
package ctrl_pkg;

   import isa_pkg::*;

   typedef enum logic [2:0] {
      ROL, SLL, ROR, SRL, ADD, AND, BTR, XOR
   } alu_op_t;

   typedef enum logic [1:0] {
      ZEXT5,    // zext(instr[4:0])
      SEXT5,    // sext(instr[4:0])
      SEXT8,    // sext(instr[7:0])
      SEXT11    // sext(instr[10:0])
   } sext_op_t;

   typedef enum logic [2:0] {
      ALU, MEM, LINK, SET, IMM, SLBI
   } wr_sel_t;

   typedef enum logic [1:0] {
      RD_4_2, RT_7_5, RS_10_8, R7
   } wr_reg_sel_t;

   typedef enum logic [1:0] {
      EQZ, NEZ, LTZ, GEZ
   } br_cnd_t;

   typedef enum logic [1:0] {
      CO, EQ, LT, LE
   } set_sel_t;

   typedef struct packed {
      br_cnd_t     br_cnd;
      set_sel_t    set_sel;
      logic        wr_en;       // Register write
      logic        mem_wr_en;   // Data memory write
      logic        mem_en;      // Data memory access
      wr_sel_t     wr_sel;
      wr_reg_sel_t wr_reg_sel;
      logic        oprnd_sel;   // Immediate as operand B
      logic        jmp_reg;     // Target from Rs
      logic        jmp;
      logic        br;
      sext_op_t    sext_op;
      alu_op_t     alu_op;
      logic        alu_inv_a;
      logic        alu_inv_b;
      logic        alu_cin;
      logic        alu_sign;    // Signed compare
      logic        pc_en;       // Low on HALT
      logic        err;         // Undefined opcode
   } ctrl_t;

   typedef struct packed {
      logic     valid;
      reg_idx_t idx;
      word_t    data;
   } wb_t;

endpackage

// File: hw/isa_pkg.sv
package isa_pkg;

   typedef logic [15:0] word_t;       // Data, address and instruction word
   typedef logic [2:0]  reg_idx_t;    // Register file index
   typedef logic [4:0]  opcode_t;     // Major opcode, instr[15:11]

   localparam opcode_t OP_HALT  = 5'b00000;
   localparam opcode_t OP_NOP   = 5'b00001;
   localparam opcode_t OP_SIIC  = 5'b00010;  // Runs as a NOP
   localparam opcode_t OP_RTI   = 5'b00011;  // Runs as a NOP
   localparam opcode_t OP_J     = 5'b00100;
   localparam opcode_t OP_JR    = 5'b00101;
   localparam opcode_t OP_JAL   = 5'b00110;
   localparam opcode_t OP_JALR  = 5'b00111;
   localparam opcode_t OP_ADDI  = 5'b01000;
   localparam opcode_t OP_SUBI  = 5'b01001;
   localparam opcode_t OP_XORI  = 5'b01010;
   localparam opcode_t OP_ANDNI = 5'b01011;
   localparam opcode_t OP_BEQZ  = 5'b01100;
   localparam opcode_t OP_BNEZ  = 5'b01101;
   localparam opcode_t OP_BLTZ  = 5'b01110;
   localparam opcode_t OP_BGEZ  = 5'b01111;
   localparam opcode_t OP_ST    = 5'b10000;
   localparam opcode_t OP_LD    = 5'b10001;
   localparam opcode_t OP_SLBI  = 5'b10010;
   localparam opcode_t OP_STU   = 5'b10011;
   localparam opcode_t OP_ROLI  = 5'b10100;
   localparam opcode_t OP_SLLI  = 5'b10101;
   localparam opcode_t OP_RORI  = 5'b10110;
   localparam opcode_t OP_SRLI  = 5'b10111;
   localparam opcode_t OP_LBI   = 5'b11000;
   localparam opcode_t OP_BTR   = 5'b11001;
   localparam opcode_t OP_SHIFT = 5'b11010;  // ROL, SLL, ROR, SRL by instr[1:0]
   localparam opcode_t OP_ARITH = 5'b11011;  // ADD, SUB, XOR, ANDN by instr[1:0]
   localparam opcode_t OP_SEQ   = 5'b11100;
   localparam opcode_t OP_SLT   = 5'b11101;
   localparam opcode_t OP_SLE   = 5'b11110;
   localparam opcode_t OP_SCO   = 5'b11111;

   localparam int IMEM_WORDS = 256;
   localparam int DMEM_WORDS = 256;

   typedef logic [7:0] imem_addr_t;   // Word index into instruction memory
   typedef logic [7:0] dmem_addr_t;   // Word index into data memory

   localparam reg_idx_t LINK_REG = 3'd7;

endpackage
